//--- rtl/rv_decode_pkg.sv
// Shared widths, RV32I encodings, trap causes and stage structs for the ID stage.
package rv_decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int cause_w    = 4;

    // Major opcodes, instruction bits 6:2.
    localparam logic [4:0] op_load     = 5'b00000;
    localparam logic [4:0] op_misc_mem = 5'b00011;
    localparam logic [4:0] op_op_imm   = 5'b00100;
    localparam logic [4:0] op_auipc    = 5'b00101;
    localparam logic [4:0] op_store    = 5'b01000;
    localparam logic [4:0] op_op       = 5'b01100;
    localparam logic [4:0] op_lui      = 5'b01101;
    localparam logic [4:0] op_branch   = 5'b11000;
    localparam logic [4:0] op_jalr     = 5'b11001;
    localparam logic [4:0] op_jal      = 5'b11011;
    localparam logic [4:0] op_system   = 5'b11100;

    // ALU funct3 codes with extra funct7 rules.
    localparam logic [2:0] funct3_add = 3'b000;
    localparam logic [2:0] funct3_sll = 3'b001;
    localparam logic [2:0] funct3_srl = 3'b101;

    localparam logic [cause_w-1:0] cause_illegal = 4'd2;
    localparam logic [cause_w-1:0] cause_ebreak  = 4'd3;
    localparam logic [cause_w-1:0] cause_m_ecall = 4'd11;

    // Instruction formats. Each ends in the opcode and the length bits.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] len;
    } fmt_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  len;
    } fmt_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [4:0] opcode;
        logic [1:0] len;
    } fmt_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [4:0] opcode;
        logic [1:0] len;
    } fmt_b_t;

    typedef struct packed {
        logic [19:0] imm_hi;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  len;
    } fmt_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] len;
    } fmt_j_t;

    typedef union packed {
        logic [31:0] raw;
        fmt_r_t      r;
        fmt_i_t      i;
        fmt_s_t      s;
        fmt_b_t      b;
        fmt_u_t      u;
        fmt_j_t      j;
    } insn_t;

    // One item from fetch.
    typedef struct packed {
        logic [xlen-1:1]    pc;
        insn_t              insn;
        logic               trap;
        logic [cause_w-1:0] cause;
    } id_in_t;

    // One register write from write-back.
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wdata;
    } wb_t;

    // One decoded item toward execute.
    typedef struct packed {
        logic [xlen-1:1]    pc;
        insn_t              insn;
        logic               use_rd;
        logic [xlen-1:0]    rs1_val;
        logic [xlen-1:0]    rs2_val;
        logic               is_branch;
        logic               predict_taken;
        logic               is_jump;
        logic               is_xret;
        logic [xlen-1:1]    target;
        logic               trap;
        logic [cause_w-1:0] cause;
    } id_out_t;

endpackage

//--- rtl/rv_regfile.sv
// Read-first RV32 register file with two combinational reads, instantiated by the ID stage.
module rv_regfile (
    input  logic                                  clk,
    input  logic                                  rst,
    input  rv_decode_pkg::wb_t                    wb,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_decode_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_decode_pkg::xlen-1:0]       rs1_val,
    output logic [rv_decode_pkg::xlen-1:0]       rs2_val
);

    // x0 has no storage.
    logic [rv_decode_pkg::xlen-1:0] regs [31:1];

    // Reads see the value from before any write on this edge.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

endmodule

//--- rtl/rv_insn_check.sv
// RV32I and Zicsr encoding check with ECALL, EBREAK and MRET detection for the ID stage.
module rv_insn_check (
    input  rv_decode_pkg::insn_t insn,
    output logic                 valid,
    output logic                 is_ecall,
    output logic                 is_ebreak,
    output logic                 is_mret
);

    logic valid_op_imm;
    logic valid_op;
    logic valid_system;
    logic priv_form;
    logic is_wfi;

    // OP-IMM shifts carry funct7 in the upper immediate bits.
    always_comb begin
        if (insn.r.funct3 == rv_decode_pkg::funct3_sll) begin
            valid_op_imm = (insn.r.funct7 == 7'b0000000);
        end else if (insn.r.funct3 == rv_decode_pkg::funct3_srl) begin
            // SRLI or SRAI.
            valid_op_imm = (insn.r.funct7 == 7'b0000000) || (insn.r.funct7 == 7'b0100000);
        end else begin
            valid_op_imm = 1'b1;
        end
    end

    // Only ADD/SUB and SRL/SRA have a second funct7 form.
    always_comb begin
        if (insn.r.funct3 == rv_decode_pkg::funct3_add ||
            insn.r.funct3 == rv_decode_pkg::funct3_srl) begin
            valid_op = (insn.r.funct7 == 7'b0000000) || (insn.r.funct7 == 7'b0100000);
        end else begin
            valid_op = (insn.r.funct7 == 7'b0000000);
        end
    end

    // Privileged forms need rs1, rd and funct3 all zero.
    assign priv_form = (insn.i.len == 2'b11) &&
                       (insn.i.opcode == rv_decode_pkg::op_system) &&
                       (insn.i.funct3 == 3'b000) &&
                       (insn.i.rs1 == '0) &&
                       (insn.i.rd == '0);

    assign is_ecall  = priv_form && (insn.i.imm == 12'h000);
    assign is_ebreak = priv_form && (insn.i.imm == 12'h001);
    assign is_mret   = priv_form && (insn.i.imm == 12'h302);
    assign is_wfi    = priv_form && (insn.i.imm == 12'h105);

    always_comb begin
        if (insn.i.funct3 == 3'b000) begin
            valid_system = is_ecall || is_ebreak || is_mret || is_wfi;
        end else begin
            // CSR forms; funct3 100 is unused.
            valid_system = (insn.i.funct3 != 3'b100);
        end
    end

    always_comb begin
        if (insn.r.len != 2'b11) begin
            valid = 1'b0;
        end else begin
            case (insn.r.opcode)
                rv_decode_pkg::op_load: begin
                    // LB, LH, LW, LBU and LHU.
                    valid = (insn.i.funct3 != 3'b011) && (insn.i.funct3[2:1] != 2'b11);
                end
                rv_decode_pkg::op_misc_mem: valid = (insn.i.funct3 == 3'b000);
                rv_decode_pkg::op_op_imm:   valid = valid_op_imm;
                rv_decode_pkg::op_auipc:    valid = 1'b1;
                rv_decode_pkg::op_store:    valid = (insn.s.funct3 < 3'd3);
                rv_decode_pkg::op_op:       valid = valid_op;
                rv_decode_pkg::op_lui:      valid = 1'b1;
                rv_decode_pkg::op_branch: begin
                    // funct3 010 and 011 are not branches.
                    valid = insn.b.funct3[2] || !insn.b.funct3[1];
                end
                rv_decode_pkg::op_jalr:     valid = (insn.i.funct3 == 3'b000);
                rv_decode_pkg::op_jal:      valid = 1'b1;
                rv_decode_pkg::op_system:   valid = valid_system;
                default:                    valid = 1'b0;
            endcase
        end
    end

endmodule

//--- rtl/rv_operand_decode.sv
// Opcode table of which registers an instruction reads and writes, used by the ID stage.
module rv_operand_decode (
    input  rv_decode_pkg::insn_t insn,
    output logic                 use_rs1,
    output logic                 use_rs2,
    output logic                 use_rd
);

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_rd  = 1'b0;
        case (insn.u.opcode)
            rv_decode_pkg::op_load:   {use_rs1, use_rs2, use_rd} = 3'b101;
            rv_decode_pkg::op_op_imm: {use_rs1, use_rs2, use_rd} = 3'b101;
            rv_decode_pkg::op_auipc:  {use_rs1, use_rs2, use_rd} = 3'b001;
            rv_decode_pkg::op_store:  {use_rs1, use_rs2, use_rd} = 3'b110;
            rv_decode_pkg::op_op:     {use_rs1, use_rs2, use_rd} = 3'b111;
            rv_decode_pkg::op_lui:    {use_rs1, use_rs2, use_rd} = 3'b001;
            rv_decode_pkg::op_branch: {use_rs1, use_rs2, use_rd} = 3'b110;
            rv_decode_pkg::op_jalr:   {use_rs1, use_rs2, use_rd} = 3'b101;
            rv_decode_pkg::op_jal:    {use_rs1, use_rs2, use_rd} = 3'b001;
            rv_decode_pkg::op_system: begin
                if (insn.i.funct3 != 3'b000) begin
                    // CSR forms; the immediate forms put a constant in rs1.
                    use_rs1 = !insn.i.funct3[2];
                    use_rd  = 1'b1;
                end
            end
            default: begin
                // FENCE and unknown opcodes use no registers.
            end
        endcase
    end

endmodule

//--- rtl/rv_branch_unit.sv
// Branch and jump classification, static prediction and target adder for the ID stage.
module rv_branch_unit (
    input  rv_decode_pkg::insn_t              insn,
    input  logic [rv_decode_pkg::xlen-1:1]   pc,
    input  logic [rv_decode_pkg::xlen-1:0]   rs1_val,
    output logic                              is_branch,
    output logic                              is_jump,
    output logic                              predict_taken,
    output logic [rv_decode_pkg::xlen-1:1]   target
);

    logic [rv_decode_pkg::xlen-1:0] imm_i;
    logic [rv_decode_pkg::xlen-1:0] imm_b;
    logic [rv_decode_pkg::xlen-1:0] imm_j;
    logic [rv_decode_pkg::xlen-1:0] add_lhs;
    logic [rv_decode_pkg::xlen-1:0] add_rhs;
    logic [rv_decode_pkg::xlen-1:0] add_res;

    // Sign-extended immediates.
    assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
    assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                    insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
    assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                    insn.j.imm_11, insn.j.imm_10_1, 1'b0};

    always_comb begin
        is_branch = 1'b0;
        is_jump   = 1'b0;
        add_lhs   = {pc, 1'b0};
        add_rhs   = '0;
        case (insn.j.opcode)
            rv_decode_pkg::op_jal: begin
                is_jump = 1'b1;
                add_rhs = imm_j;
            end
            rv_decode_pkg::op_jalr: begin
                is_jump = 1'b1;
                add_lhs = rs1_val;
                add_rhs = imm_i;
            end
            rv_decode_pkg::op_branch: begin
                is_branch = 1'b1;
                add_rhs   = imm_b;
            end
            default: begin
                // Not a control transfer; target is just the PC.
            end
        endcase
    end

    assign add_res = add_lhs + add_rhs;

    // JALR clears bit 0 of the sum.
    assign target = add_res[rv_decode_pkg::xlen-1:1];

    // Backward branches have a negative offset.
    assign predict_taken = insn.raw[31];

endmodule

//--- rtl/rv_id_stage.sv
// RV32I decode stage top with valid/ready handshake, barrier register and trap priority.
module rv_id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rv_decode_pkg::id_in_t  in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rv_decode_pkg::id_out_t out_data,
    input  rv_decode_pkg::wb_t     wb
);

    // Barrier register.
    logic                  r_valid;
    rv_decode_pkg::id_in_t r_data;

    logic [rv_decode_pkg::reg_addr_w-1:0] rs1_idx;
    logic [rv_decode_pkg::reg_addr_w-1:0] rs2_idx;
    logic [rv_decode_pkg::xlen-1:0]       rs1_val;
    logic [rv_decode_pkg::xlen-1:0]       rs2_val;

    logic insn_valid;
    logic is_ecall;
    logic is_ebreak;
    logic is_mret;
    logic use_rs1;
    logic use_rs2;
    logic use_rd;
    logic is_branch;
    logic is_jump;
    logic predict_taken;
    logic [rv_decode_pkg::xlen-1:1] target;

    logic                              trap;
    logic [rv_decode_pkg::cause_w-1:0] cause;

    // Accept when empty or when the held item leaves on this edge.
    assign in_ready  = !r_valid || out_ready;
    assign out_valid = r_valid && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (in_ready) begin
            r_valid <= in_valid;
        end else if (flush) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            r_data <= in_data;
        end
    end

    // Unused operands read as x0.
    assign rs1_idx = use_rs1 ? r_data.insn.r.rs1 : '0;
    assign rs2_idx = use_rs2 ? r_data.insn.r.rs2 : '0;

    rv_regfile regfile_i (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1     (rs1_idx),
        .rs2     (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    rv_insn_check insn_check_i (
        .insn      (r_data.insn),
        .valid     (insn_valid),
        .is_ecall  (is_ecall),
        .is_ebreak (is_ebreak),
        .is_mret   (is_mret)
    );

    rv_operand_decode operand_decode_i (
        .insn    (r_data.insn),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2),
        .use_rd  (use_rd)
    );

    rv_branch_unit branch_unit_i (
        .insn          (r_data.insn),
        .pc            (r_data.pc),
        .rs1_val       (rs1_val),
        .is_branch     (is_branch),
        .is_jump       (is_jump),
        .predict_taken (predict_taken),
        .target        (target)
    );

    // Fetch trap first, then illegal, ECALL, EBREAK.
    always_comb begin
        trap  = 1'b1;
        cause = r_data.cause;
        if (r_data.trap) begin
            cause = r_data.cause;
        end else if (!insn_valid) begin
            cause = rv_decode_pkg::cause_illegal;
        end else if (is_ecall) begin
            cause = rv_decode_pkg::cause_m_ecall;
        end else if (is_ebreak) begin
            cause = rv_decode_pkg::cause_ebreak;
        end else begin
            trap  = 1'b0;
            cause = '0;
        end
    end

    always_comb begin
        out_data.pc            = r_data.pc;
        out_data.insn          = r_data.insn;
        out_data.use_rd        = use_rd;
        out_data.rs1_val       = rs1_val;
        out_data.rs2_val       = rs2_val;
        out_data.is_branch     = is_branch;
        out_data.predict_taken = predict_taken;
        out_data.is_jump       = is_jump;
        out_data.is_xret       = is_mret;
        out_data.target        = target;
        out_data.trap          = trap;
        out_data.cause         = cause;
    end

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and reset source with an 8 ns clock and reset held high for the first 16 cycles.
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period  = 4;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Released on a rising edge like any other driven input.
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- sim/tb_rv_id_stage.sv
// Testbench top for the ID stage; drives fetch items and write-backs and checks every transfer.
module tb_rv_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    // Items per test, writes included, for the watchdog.
    localparam int items_regs    = 9;
    localparam int items_illegal = 5;
    localparam int items_traps   = 6;
    localparam int items_branch  = 6;
    localparam int items_stream  = 41;
    localparam int items_flush   = 5;
    localparam int total_items   = items_regs + items_illegal + items_traps +
                                   items_branch + items_stream + items_flush;
    localparam int watchdog_ns   = (total_items * 20 + 16) * 8;
    localparam int stream_len    = 40;
    localparam int drain_limit   = 200;

    typedef struct packed {
        logic                              trap;
        logic [rv_decode_pkg::cause_w-1:0] cause;
    } trap_exp_t;

    typedef struct packed {
        rv_decode_pkg::id_out_t val;
        rv_decode_pkg::id_out_t mask;
    } exp_item_t;

    localparam trap_exp_t no_trap = '0;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   in_valid;
    logic                   in_ready;
    rv_decode_pkg::id_in_t  in_data;
    logic                   out_valid;
    logic                   out_ready;
    rv_decode_pkg::id_out_t out_data;
    rv_decode_pkg::wb_t     wb;

    // Reference model state.
    exp_item_t   exp_q[$];
    exp_item_t   exp_head;
    logic        exp_avail;
    trap_exp_t   trap_drv;
    logic [31:0] mregs [0:31];
    logic [31:0] words [0:stream_len-1];
    logic [1:0]  ready_mode;
    int          seed = 33245;
    int          ready_rnd;
    int          word_rnd;
    int          err_count;
    int          errs_at_start;
    int          tests_run;
    int          tests_failed;
    int          n_sent;
    int          n_recv;
    int          n_flushed;

    tb_clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    rv_id_stage rv_id_stage_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .wb        (wb)
    );

    // Mode 0 always ready, 1 random, 2 held low.
    always @(posedge clk) begin
        case (ready_mode)
            2'd0: out_ready <= 1'b1;
            2'd1: begin
                ready_rnd = $random(seed);
                out_ready <= ready_rnd[0];
            end
            default: out_ready <= 1'b0;
        endcase
    end

    function automatic exp_item_t predict(rv_decode_pkg::id_in_t item, trap_exp_t tr);
        logic [31:0] w;
        logic [31:0] pc_full;
        logic [31:0] sum;
        logic        rs1_used;
        logic        rs2_used;
        exp_item_t   e;
        w        = item.insn.raw;
        pc_full  = {item.pc, 1'b0};
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        e.val    = '0;
        e.mask   = '1;
        case (w[6:2])
            rv_decode_pkg::op_lui, rv_decode_pkg::op_auipc, rv_decode_pkg::op_jal: begin
                e.val.use_rd = 1'b1;
            end
            rv_decode_pkg::op_load, rv_decode_pkg::op_op_imm, rv_decode_pkg::op_jalr: begin
                e.val.use_rd = 1'b1;
                rs1_used     = 1'b1;
            end
            rv_decode_pkg::op_op: begin
                e.val.use_rd = 1'b1;
                rs1_used     = 1'b1;
                rs2_used     = 1'b1;
            end
            rv_decode_pkg::op_store, rv_decode_pkg::op_branch: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            rv_decode_pkg::op_system: begin
                // CSR forms write rd, register forms read rs1.
                e.val.use_rd = (w[14:12] != 3'b000);
                rs1_used     = (w[14:12] != 3'b000) && !w[14];
            end
            default: begin
                // No register operands.
            end
        endcase
        e.val.pc            = item.pc;
        e.val.insn          = item.insn;
        e.val.rs1_val       = rs1_used ? mregs[w[19:15]] : '0;
        e.val.rs2_val       = rs2_used ? mregs[w[24:20]] : '0;
        e.val.is_branch     = (w[6:2] == rv_decode_pkg::op_branch);
        e.val.is_jump       = (w[6:2] == rv_decode_pkg::op_jal) ||
                              (w[6:2] == rv_decode_pkg::op_jalr);
        e.val.predict_taken = w[31];
        e.val.is_xret       = (w == 32'h3020_0073);
        if (w[6:2] == rv_decode_pkg::op_jal) begin
            sum = pc_full + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:2] == rv_decode_pkg::op_jalr) begin
            sum = e.val.rs1_val + {{20{w[31]}}, w[31:20]};
        end else begin
            sum = pc_full + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
        e.val.target = sum[31:1];
        // Target only matters for control transfers.
        if (!e.val.is_branch && !e.val.is_jump) begin
            e.mask.target = '0;
        end
        e.val.trap  = tr.trap;
        e.val.cause = tr.trap ? tr.cause : '0;
        return e;
    endfunction

    // Queue bookkeeping on every edge, using the values from before the edge.
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            mregs     = '{default: '0};
            exp_avail <= 1'b0;
            exp_head  <= '0;
        end else begin
            if (wb.we && (wb.rd != '0)) begin
                mregs[wb.rd] = wb.wdata;
            end
            if (flush && (exp_q.size() > 0)) begin
                void'(exp_q.pop_front());
                n_flushed++;
            end else if (out_valid && out_ready && (exp_q.size() > 0)) begin
                void'(exp_q.pop_front());
                n_recv++;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(predict(in_data, trap_drv));
                n_sent++;
            end
            exp_avail <= (exp_q.size() > 0);
            exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
        end
    end

    check_transfer: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |->
            (exp_avail && (((out_data ^ exp_head.val) & exp_head.mask) == '0)))
    else begin
        $display("[ERROR] %0d ns: output item differs, got %h expected %h",
                 $time, $sampled(out_data), $sampled(exp_head.val));
        err_count++;
    end

    check_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready && !flush) |=> (flush || (out_valid && $stable(out_data))))
    else begin
        $display("[ERROR] %0d ns: held output item changed or vanished", $time);
        err_count++;
    end

    check_full: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |-> !in_ready)
    else begin
        $display("[ERROR] %0d ns: in_ready high while barrier is full and stalled", $time);
        err_count++;
    end

    check_flush: assert property (@(posedge clk) disable iff (rst) flush |-> !out_valid)
    else begin
        $display("[ERROR] %0d ns: out_valid high during flush", $time);
        err_count++;
    end

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
                rv_decode_pkg::op_branch, 2'b11};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_decode_pkg::op_jal, 2'b11};
    endfunction

    function automatic trap_exp_t trap_with(logic [rv_decode_pkg::cause_w-1:0] cause);
        return {1'b1, cause};
    endfunction

    // Called just after a rising edge; returns just after the accepting edge.
    task automatic send(input logic [31:0] pc, input logic [31:0] word,
                        input trap_exp_t fetch_tr, input trap_exp_t exp_tr);
        rv_decode_pkg::id_in_t d;
        d.pc       = pc[31:1];
        d.insn.raw = word;
        d.trap     = fetch_tr.trap;
        d.cause    = fetch_tr.cause;
        in_valid <= 1'b1;
        in_data  <= d;
        trap_drv <= exp_tr;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic idle(input int cycles);
        in_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic set_ready(input logic [1:0] mode);
        ready_mode <= mode;
        idle(2);
    endtask

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
        wb <= '{we: 1'b1, rd: idx, wdata: val};
        @(posedge clk);
        wb <= '0;
    endtask

    task automatic pulse_flush();
        in_valid <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        in_valid <= 1'b0;
        @(posedge clk);
        while (exp_avail && (cycles < drain_limit)) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_avail) begin
            $display("Output did not drain within %0d cycles", drain_limit);
            err_count++;
        end
    endtask

    task automatic start_test();
        errs_at_start = err_count;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, err_count - errs_at_start);
        end
    endtask

    task automatic test_regs();
        start_test();
        // Nothing written yet.
        send(32'h100, enc_r(7'h00, 5'd9, 5'd8, 3'b000, 5'd7, rv_decode_pkg::op_op),
             no_trap, no_trap);
        wait_drain();
        write_reg(5'd1, 32'h0000_4000);
        write_reg(5'd2, 32'h1234_5678);
        write_reg(5'd5, 32'h8000_0001);
        write_reg(5'd31, 32'h7fff_ffff);
        write_reg(5'd0, 32'hdead_beef);
        send(32'h104, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op),
             no_trap, no_trap);
        send(32'h108, enc_r(7'h20, 5'd31, 5'd5, 3'b000, 5'd4, rv_decode_pkg::op_op),
             no_trap, no_trap);
        send(32'h10c, enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd6, rv_decode_pkg::op_op),
             no_trap, no_trap);
        wait_drain();
        close_test("register file reads");
    endtask

    task automatic test_illegal();
        start_test();
        send(32'h200, 32'h0000_007f, no_trap, trap_with(4'd2));
        send(32'h204, 32'h0000_000b, no_trap, trap_with(4'd2));
        // SLLI with the SRAI funct7.
        send(32'h208, enc_i(12'h403, 5'd1, 3'b001, 5'd2, rv_decode_pkg::op_op_imm),
             no_trap, trap_with(4'd2));
        send(32'h20c, enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op),
             no_trap, trap_with(4'd2));
        send(32'h210, enc_i(12'h005, 5'd1, 3'b000, 5'd2, rv_decode_pkg::op_op_imm) & ~32'h3,
             no_trap, trap_with(4'd2));
        wait_drain();
        close_test("illegal instructions");
    endtask

    task automatic test_traps();
        start_test();
        send(32'h300, 32'h0000_0073, no_trap, trap_with(4'd11));
        send(32'h304, 32'h0010_0073, no_trap, trap_with(4'd3));
        send(32'h308, 32'h3020_0073, no_trap, no_trap);
        send(32'h30c, 32'h0000_007f, trap_with(4'd1), trap_with(4'd1));
        send(32'h310, 32'h0000_0073, trap_with(4'd12), trap_with(4'd12));
        // SRET is outside M-mode only.
        send(32'h314, 32'h1020_0073, no_trap, trap_with(4'd2));
        wait_drain();
        close_test("trap causes and priority");
    endtask

    task automatic test_branch();
        start_test();
        send(32'h1000, enc_j(21'd2048, 5'd1), no_trap, no_trap);
        send(32'h1100, enc_j(21'h1f_fff0, 5'd0), no_trap, no_trap);
        send(32'h2000, enc_b(13'd64, 5'd2, 5'd1, 3'b000), no_trap, no_trap);
        send(32'h2040, enc_b(13'h1fe0, 5'd31, 5'd5, 3'b001), no_trap, no_trap);
        send(32'h3000, enc_b(13'h1000, 5'd2, 5'd1, 3'b110), no_trap, no_trap);
        send(32'h3004, enc_i(12'hffc, 5'd1, 3'b000, 5'd5, rv_decode_pkg::op_jalr),
             no_trap, no_trap);
        wait_drain();
        close_test("branch and jump decoding");
    endtask

    task automatic test_backpressure();
        start_test();
        for (int k = 0; k < stream_len; k++) begin
            word_rnd = $random(seed);
            if (word_rnd[31]) begin
                words[k] = enc_b({word_rnd[11:0], 1'b0}, word_rnd[16:12], word_rnd[21:17],
                                 3'b000);
            end else begin
                words[k] = enc_i(word_rnd[11:0], word_rnd[16:12], 3'b000, word_rnd[21:17],
                                 rv_decode_pkg::op_op_imm);
            end
        end
        set_ready(2'd2);
        send(32'h7ffc, enc_i(12'h7ff, 5'd2, 3'b000, 5'd9, rv_decode_pkg::op_op_imm),
             no_trap, no_trap);
        idle(6);
        set_ready(2'd1);
        for (int k = 0; k < stream_len; k++) begin
            send(32'h8000 + 4 * k, words[k], no_trap, no_trap);
        end
        set_ready(2'd0);
        wait_drain();
        close_test("back-pressure");
    endtask

    task automatic test_flush();
        start_test();
        set_ready(2'd2);
        send(32'h9000, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op),
             no_trap, no_trap);
        pulse_flush();
        set_ready(2'd0);
        send(32'h9004, enc_j(21'd16, 5'd1), no_trap, no_trap);
        send(32'h9008, 32'h0000_0073, no_trap, trap_with(4'd11));
        wait_drain();
        // Flush while the next item is offered.
        send(32'h900c, enc_b(13'd8, 5'd1, 5'd2, 3'b100), no_trap, no_trap);
        flush <= 1'b1;
        send(32'h9010, enc_i(12'h010, 5'd1, 3'b000, 5'd4, rv_decode_pkg::op_op_imm),
             no_trap, no_trap);
        flush <= 1'b0;
        wait_drain();
        close_test("flush");
    endtask

    initial begin
        #watchdog_ns;
        $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        flush      = 1'b0;
        wb         = '0;
        trap_drv   = '0;
        ready_mode = 2'd0;
        err_count  = 0;
        tests_run  = 0;
        n_sent     = 0;
        n_recv     = 0;
        n_flushed  = 0;
        tests_failed = 0;
        wait (rst == 1'b0);
        @(posedge clk);
        assert (!out_valid && in_ready) else begin
            $display("[ERROR] %0d ns: wrong handshake state after reset", $time);
            err_count++;
        end
        test_regs();
        test_illegal();
        test_traps();
        test_branch();
        test_backpressure();
        test_flush();
        assert ((exp_q.size() == 0) && (n_sent == n_recv + n_flushed)) else begin
            $display("[ERROR] %0d ns: %0d items sent, %0d received, %0d flushed", $time,
                     n_sent, n_recv, n_flushed);
            err_count++;
        end
        $display("Tests %0d, failed %0d; sent %0d, received %0d, flushed %0d; errors %0d",
                 tests_run, tests_failed, n_sent, n_recv, n_flushed, err_count);
        if ((err_count == 0) && (tests_failed == 0)) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/rv_decode_pkg.sv
rtl/rv_regfile.sv
rtl/rv_insn_check.sv
rtl/rv_operand_decode.sv
rtl/rv_branch_unit.sv
rtl/rv_id_stage.sv
sim/tb_clock_gen.sv
sim/tb_rv_id_stage.sv

//--- Bender.yml
package:
  name: rv_id_stage

sources:
  - rtl/rv_decode_pkg.sv
  - rtl/rv_regfile.sv
  - rtl/rv_insn_check.sv
  - rtl/rv_operand_decode.sv
  - rtl/rv_branch_unit.sv
  - rtl/rv_id_stage.sv
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_rv_id_stage.sv
